/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_csr_unit
FILELIST  := csr_unit.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation FAILED"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* csr_op_decode.sv */
`timescale 1ns/10ps

module csr_op_decode (
    input  logic                csr_valid_i,
    input  csr_pkg::csr_op_t    csr_op_i,
    input  csr_pkg::csr_word_t  csr_wdata_i,
    input  csr_pkg::csr_word_t  csr_rdata_i,
    output logic                csr_we_o,
    output logic                csr_re_o,
    output logic                mret_o,
    output csr_pkg::csr_word_t  wdata_o
);

    import csr_pkg::*;

    // ========================================================================
    // op decode and read-modify-write value
    // ========================================================================

    always_comb begin
        logic      acc;
        logic      ret;
        csr_word_t nxt;

        acc = 1'b0;
        ret = 1'b0;
        nxt = csr_wdata_i;

        if (csr_valid_i) begin
            case (csr_op_i)
                CSR_RW: begin
                    acc = 1'b1;
                    nxt = csr_wdata_i;
                end
                // set and clear work on the merged old value
                CSR_SET: begin
                    acc = 1'b1;
                    nxt = csr_rdata_i | csr_wdata_i;
                end
                CSR_CLEAR: begin
                    acc = 1'b1;
                    nxt = csr_rdata_i & ~csr_wdata_i;
                end
                // return has no csr side effects
                CSR_MRET: begin
                    ret = 1'b1;
                end
                default: begin
                    acc = 1'b0;
                end
            endcase
        end

        csr_we_o = acc;
        csr_re_o = acc;
        mret_o   = ret;
        wdata_o  = nxt;
    end

endmodule

/* csr_pkg.sv */
package csr_pkg;

    // ========================================================================
    // data types
    // ========================================================================

    // one csr data word
    typedef logic [31:0] csr_word_t;

    // 12-bit csr address space
    typedef logic [11:0] csr_addr_t;

    // index into the mvu configuration file
    typedef logic [3:0]  mvu_idx_t;

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_RW    = 3'd1,
        CSR_SET   = 3'd2,
        CSR_CLEAR = 3'd3,
        CSR_MRET  = 3'd4
    } csr_op_t;

    // ========================================================================
    // csr addresses
    // ========================================================================

    // machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MIP       = 12'h344;

    // counters
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;

    // id registers, all read only
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    // mvu block, config registers sit at base + index
    localparam csr_addr_t MVU_CSR_BASE   = 12'h7C0;
    localparam csr_addr_t ADDR_MVUSTATUS = 12'h7D0;

    localparam int        MVU_NUM_REGS   = 16;
    // writing this one kicks off the accelerator
    localparam mvu_idx_t  MVU_CMD_INDEX  = 4'd15;

    // ========================================================================
    // bit positions and constants
    // ========================================================================

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int IRQ_MVU_BIT      = 16;

    // interrupt flag in bit 31, mvu line as the code
    localparam csr_word_t MVU_IRQ_CAUSE = 32'h8000_0000 | 32'(IRQ_MVU_BIT);

    localparam csr_word_t VENDOR_ID = 32'h0000_0000;
    localparam csr_word_t ARCH_ID   = 32'h0000_0019;
    localparam csr_word_t IMP_ID    = 32'h0000_0000;
    localparam csr_word_t HART_ID   = 32'h0000_0000;
    // rv32i only
    localparam csr_word_t ISA_CODE  = 32'h4000_0100;

endpackage

/* csr_unit.f */
csr_pkg.sv
csr_op_decode.sv
machine_csr_regs.sv
mvu_csr_file.sv
csr_unit_top.sv
tb_csr_unit.sv

/* csr_unit_top.sv */
`timescale 1ns/10ps

module csr_unit_top (
    input  logic                clk,
    input  logic                rst_n,
    // csr access port
    input  logic                csr_valid_i,
    input  csr_pkg::csr_op_t    csr_op_i,
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  csr_pkg::csr_word_t  csr_wdata_i,
    output csr_pkg::csr_word_t  csr_rdata_o,
    output logic                csr_illegal_o,
    // core side
    input  csr_pkg::csr_word_t  pc_i,
    input  csr_pkg::csr_word_t  boot_addr_i,
    input  logic                cycle_en_i,
    output logic                evt_valid_o,
    output csr_pkg::csr_word_t  evt_pc_o,
    // mvu side
    input  logic                mvu_irq_i,
    input  logic                mvu_status_i,
    output csr_pkg::csr_word_t  mvu_cfg_o [csr_pkg::MVU_NUM_REGS],
    output logic                mvu_start_o
);

    import csr_pkg::*;

    logic      csr_we;
    logic      csr_re;
    logic      mret;
    csr_word_t wdata;

    csr_word_t mach_rdata;
    logic      mach_hit;
    logic      mach_illegal;
    csr_word_t mvu_rdata;
    logic      mvu_hit;
    logic      mvu_illegal;

    csr_op_decode u_decode (
        .csr_valid_i (csr_valid_i),
        .csr_op_i    (csr_op_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_i (csr_rdata_o),
        .csr_we_o    (csr_we),
        .csr_re_o    (csr_re),
        .mret_o      (mret),
        .wdata_o     (wdata)
    );

    machine_csr_regs u_machine (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_addr_i  (csr_addr_i),
        .csr_we_i    (csr_we),
        .csr_re_i    (csr_re),
        .mret_i      (mret),
        .wdata_i     (wdata),
        .pc_i        (pc_i),
        .boot_addr_i (boot_addr_i),
        .mvu_irq_i   (mvu_irq_i),
        .cycle_en_i  (cycle_en_i),
        .rdata_o     (mach_rdata),
        .hit_o       (mach_hit),
        .illegal_o   (mach_illegal),
        .evt_valid_o (evt_valid_o),
        .evt_pc_o    (evt_pc_o)
    );

    mvu_csr_file u_mvu (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_addr_i   (csr_addr_i),
        .csr_we_i     (csr_we),
        .csr_re_i     (csr_re),
        .wdata_i      (wdata),
        .mvu_status_i (mvu_status_i),
        .rdata_o      (mvu_rdata),
        .hit_o        (mvu_hit),
        .illegal_o    (mvu_illegal),
        .mvu_cfg_o    (mvu_cfg_o),
        .mvu_start_o  (mvu_start_o)
    );

    // banks drive zero when not hit
    assign csr_rdata_o   = mach_rdata | mvu_rdata;
    // unknown address when nobody claims an access
    assign csr_illegal_o = mach_illegal | mvu_illegal |
                           ((csr_re | csr_we) & ~mach_hit & ~mvu_hit);

    bank_exclusive_a: assert property (
        @(posedge clk) disable iff (!rst_n) !(mach_hit && mvu_hit)
    ) else $error("csr_unit_top: both csr banks claim one address");

endmodule

/* machine_csr_regs.sv */
`timescale 1ns/10ps

module machine_csr_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  logic                csr_we_i,
    input  logic                csr_re_i,
    input  logic                mret_i,
    input  csr_pkg::csr_word_t  wdata_i,
    input  csr_pkg::csr_word_t  pc_i,
    input  csr_pkg::csr_word_t  boot_addr_i,
    input  logic                mvu_irq_i,
    input  logic                cycle_en_i,
    output csr_pkg::csr_word_t  rdata_o,
    output logic                hit_o,
    output logic                illegal_o,
    output logic                evt_valid_o,
    output csr_pkg::csr_word_t  evt_pc_o
);

    import csr_pkg::*;

    // only the implemented bits are kept as flops
    logic        mstatus_mie_q;
    logic        mstatus_mpie_q;
    logic        mie_mvu_q;
    logic        mip_mvu_q;
    csr_word_t   mtvec_q;
    csr_word_t   mepc_q;
    csr_word_t   mcause_q;
    logic [63:0] mcycle_q;
    // high for the first clock out of reset
    logic        boot_load_q;

    logic        access;
    logic        addr_known;
    logic        read_only;
    logic        wr_ok;
    logic        irq_take;
    csr_word_t   rdata;

    // ========================================================================
    // address decode and read mux
    // ========================================================================

    always_comb begin
        addr_known = 1'b1;
        read_only  = 1'b0;
        rdata      = '0;

        case (csr_addr_i)
            ADDR_MSTATUS: begin
                rdata[MSTATUS_MIE_BIT]  = mstatus_mie_q;
                rdata[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
            end
            // writes accepted, value fixed
            ADDR_MISA:      rdata = ISA_CODE;
            ADDR_MIE:       rdata[IRQ_MVU_BIT] = mie_mvu_q;
            ADDR_MIP:       rdata[IRQ_MVU_BIT] = mip_mvu_q;
            ADDR_MTVEC:     rdata = mtvec_q;
            ADDR_MEPC:      rdata = mepc_q;
            ADDR_MCAUSE: begin
                rdata     = mcause_q;
                read_only = 1'b1;
            end
            ADDR_MCYCLE: begin
                rdata     = mcycle_q[31:0];
                read_only = 1'b1;
            end
            ADDR_MCYCLEH: begin
                rdata     = mcycle_q[63:32];
                read_only = 1'b1;
            end
            ADDR_MVENDORID: begin
                rdata     = VENDOR_ID;
                read_only = 1'b1;
            end
            ADDR_MARCHID: begin
                rdata     = ARCH_ID;
                read_only = 1'b1;
            end
            ADDR_MIMPID: begin
                rdata     = IMP_ID;
                read_only = 1'b1;
            end
            ADDR_MHARTID: begin
                rdata     = HART_ID;
                read_only = 1'b1;
            end
            default: addr_known = 1'b0;
        endcase
    end

    assign access    = csr_we_i | csr_re_i;
    assign hit_o     = access & addr_known;
    assign illegal_o = hit_o & read_only;
    assign rdata_o   = hit_o ? rdata : '0;
    assign wr_ok     = csr_we_i & addr_known & ~read_only;

    // ========================================================================
    // trap event
    // ========================================================================

    assign irq_take    = mstatus_mie_q & mie_mvu_q & mip_mvu_q;
    assign evt_valid_o = irq_take | mret_i;
    // interrupt beats mret
    assign evt_pc_o    = irq_take ? mtvec_q : mepc_q;

    // ========================================================================
    // state update
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_mvu_q      <= 1'b0;
            mip_mvu_q      <= 1'b0;
            mtvec_q        <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mcycle_q       <= '0;
            boot_load_q    <= 1'b1;
        end else begin
            boot_load_q <= 1'b0;
            if (boot_load_q) begin
                mtvec_q <= boot_addr_i;
            end
            if (cycle_en_i) begin
                mcycle_q <= mcycle_q + 64'd1;
            end

            // pending bit is sticky, the mvu line always sets it
            mip_mvu_q <= mip_mvu_q | mvu_irq_i;

            if (wr_ok) begin
                case (csr_addr_i)
                    ADDR_MSTATUS: begin
                        mstatus_mie_q  <= wdata_i[MSTATUS_MIE_BIT];
                        mstatus_mpie_q <= wdata_i[MSTATUS_MPIE_BIT];
                    end
                    ADDR_MIE:   mie_mvu_q <= wdata_i[IRQ_MVU_BIT];
                    ADDR_MIP:   mip_mvu_q <= wdata_i[IRQ_MVU_BIT] | mvu_irq_i;
                    ADDR_MTVEC: mtvec_q   <= wdata_i;
                    ADDR_MEPC:  mepc_q    <= {wdata_i[31:1], 1'b0};
                    default: begin
                        mepc_q <= mepc_q;
                    end
                endcase
            end

            // trap entry and return override software writes
            if (irq_take) begin
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q  <= 1'b0;
                mepc_q         <= pc_i;
                mcause_q       <= MVU_IRQ_CAUSE;
            end else if (mret_i) begin
                mstatus_mie_q  <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
            end
        end
    end

    // mie drops on entry, so an interrupt event is a single cycle
    irq_evt_single_a: assert property (
        @(posedge clk) disable iff (!rst_n) irq_take |=> !irq_take
    ) else $error("machine_csr_regs: interrupt event held two cycles");

endmodule

/* mvu_csr_file.sv */
`timescale 1ns/10ps

module mvu_csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  logic                csr_we_i,
    input  logic                csr_re_i,
    input  csr_pkg::csr_word_t  wdata_i,
    input  logic                mvu_status_i,
    output csr_pkg::csr_word_t  rdata_o,
    output logic                hit_o,
    output logic                illegal_o,
    output csr_pkg::csr_word_t  mvu_cfg_o [csr_pkg::MVU_NUM_REGS],
    output logic                mvu_start_o
);

    import csr_pkg::*;

    csr_word_t cfg_q [MVU_NUM_REGS];
    logic      start_q;

    logic      access;
    logic      cfg_hit;
    logic      status_hit;
    logic      wr_ok;
    logic      cmd_wr;
    mvu_idx_t  idx;
    csr_word_t status_word;

    // ========================================================================
    // decode
    // ========================================================================

    assign access     = csr_we_i | csr_re_i;
    assign cfg_hit    = (csr_addr_i >= MVU_CSR_BASE) &&
                        (csr_addr_i < (MVU_CSR_BASE + csr_addr_t'(MVU_NUM_REGS)));
    assign status_hit = (csr_addr_i == ADDR_MVUSTATUS);
    assign idx        = mvu_idx_t'(csr_addr_i - MVU_CSR_BASE);

    assign hit_o      = access & (cfg_hit | status_hit);
    // status word is read only, any access to it traps
    assign illegal_o  = access & status_hit;

    assign wr_ok      = csr_we_i & cfg_hit;
    assign cmd_wr     = wr_ok & (idx == MVU_CMD_INDEX);

    // busy flag zero extended
    assign status_word = {31'b0, mvu_status_i};

    always_comb begin
        rdata_o = '0;
        if (access && cfg_hit) begin
            rdata_o = cfg_q[idx];
        end else if (access && status_hit) begin
            rdata_o = status_word;
        end
    end

    // ========================================================================
    // config registers and start pulse
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MVU_NUM_REGS; i++) begin
                cfg_q[i] <= '0;
            end
            start_q <= 1'b0;
        end else begin
            if (wr_ok) begin
                cfg_q[idx] <= wdata_i;
            end
            // a back to back command folds into the pulse already going out
            start_q <= cmd_wr & ~start_q;
        end
    end

    assign mvu_cfg_o   = cfg_q;
    assign mvu_start_o = start_q;

    start_single_a: assert property (
        @(posedge clk) disable iff (!rst_n) mvu_start_o |=> !mvu_start_o
    ) else $error("mvu_csr_file: start pulse longer than one cycle");

endmodule

/* tb_csr_unit.sv */
`timescale 1ns/10ps

module tb_csr_unit;

    import csr_pkg::*;

    localparam int RW_COUNT    = 150;
    localparam int SC_COUNT    = 150;
    // reset, counting, two steps per rw access, illegal, start and irq tests
    localparam int TEST_CYCLES = 10 + 60 + 2 * RW_COUNT + SC_COUNT + 80 + 10 + 20;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 200) * 20;

    localparam csr_addr_t RO_ADDRS [8] = '{ADDR_MCAUSE, ADDR_MCYCLE, ADDR_MCYCLEH,
        ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID, ADDR_MVUSTATUS};
    localparam csr_addr_t BAD_ADDRS [4] = '{12'h000, 12'h7BF, 12'h7D1, 12'hFFF};
    localparam csr_addr_t ADDR_MVUCMD   = MVU_CSR_BASE + 12'd15;

    logic      clk;
    logic      rst_n;
    logic      csr_valid_i;
    csr_op_t   csr_op_i;
    csr_addr_t csr_addr_i;
    csr_word_t csr_wdata_i;
    csr_word_t csr_rdata_o;
    logic      csr_illegal_o;
    csr_word_t pc_i;
    csr_word_t boot_addr_i;
    logic      cycle_en_i;
    logic      evt_valid_o;
    csr_word_t evt_pc_o;
    logic      mvu_irq_i;
    logic      mvu_status_i;
    csr_word_t mvu_cfg_o [MVU_NUM_REGS];
    logic      mvu_start_o;

    // reference model of every csr
    logic        m_mie, m_mpie, m_mie_mvu, m_mip_mvu, m_start;
    csr_word_t   m_mtvec, m_mepc, m_mcause;
    logic [63:0] m_cycle;
    csr_word_t   m_cfg [MVU_NUM_REGS];

    // levels that step applies on the falling edge
    logic        count_en;
    logic        busy;
    logic [31:0] lfsr;
    int          checks, errors, test_errors, tests;

    csr_unit_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (test_errors == 0) $display("test %0d %s: ok", tests, name);
        else $display("test %0d %s: %0d mismatches", tests, name, test_errors);
        test_errors = 0;
    endtask

    // value a read sees, whether the address exists, whether it is read only
    function automatic csr_word_t model_read(input csr_addr_t a, output logic known,
                                             output logic ro);
        csr_word_t v;
        v = '0;
        known = 1'b1;
        ro = 1'b0;
        if (a >= MVU_CSR_BASE && a < MVU_CSR_BASE + 12'd16) begin
            v = m_cfg[a[3:0]];
        end else begin
            case (a)
                ADDR_MSTATUS: begin
                    v[MSTATUS_MIE_BIT]  = m_mie;
                    v[MSTATUS_MPIE_BIT] = m_mpie;
                end
                ADDR_MISA:      v = ISA_CODE;
                ADDR_MIE:       v[IRQ_MVU_BIT] = m_mie_mvu;
                ADDR_MIP:       v[IRQ_MVU_BIT] = m_mip_mvu;
                ADDR_MTVEC:     v = m_mtvec;
                ADDR_MEPC:      v = m_mepc;
                ADDR_MCAUSE:    v = m_mcause;
                ADDR_MCYCLE:    v = m_cycle[31:0];
                ADDR_MCYCLEH:   v = m_cycle[63:32];
                ADDR_MVENDORID: v = VENDOR_ID;
                ADDR_MARCHID:   v = ARCH_ID;
                ADDR_MIMPID:    v = IMP_ID;
                ADDR_MHARTID:   v = HART_ID;
                ADDR_MVUSTATUS: v = {31'b0, mvu_status_i};
                default:        known = 1'b0;
            endcase
        end
        foreach (RO_ADDRS[i]) begin
            if (known && a == RO_ADDRS[i]) begin
                ro = 1'b1;
            end
        end
        return v;
    endfunction

    // ========================================================================
    // one clock: drive at the falling edge, check mid-cycle, advance the model
    // ========================================================================

    task automatic step(input logic valid, input csr_op_t op, input csr_addr_t addr,
                        input csr_word_t wdata, input logic irq);
        csr_word_t old;
        csr_word_t nv;
        logic      known, ro, acc, ret, wr, take;
        @(negedge clk);
        csr_valid_i  = valid;
        csr_op_i     = op;
        csr_addr_i   = addr;
        csr_wdata_i  = wdata;
        mvu_irq_i    = irq;
        cycle_en_i   = count_en;
        mvu_status_i = busy;
        pc_i         = rand_bits(30) << 2;
        #5;
        old  = model_read(addr, known, ro);
        acc  = valid && (op == CSR_RW || op == CSR_SET || op == CSR_CLEAR);
        ret  = valid && (op == CSR_MRET);
        take = m_mie && m_mie_mvu && m_mip_mvu;
        check("csr_rdata_o", (acc && known) ? old : '0, csr_rdata_o);
        check("csr_illegal_o", 32'(acc && (!known || ro)), 32'(csr_illegal_o));
        check("evt_valid_o", 32'(take || ret), 32'(evt_valid_o));
        if (take) check("evt_pc_o", m_mtvec, evt_pc_o);
        else if (ret) check("evt_pc_o", m_mepc, evt_pc_o);
        check("mvu_start_o", 32'(m_start), 32'(mvu_start_o));
        for (int i = 0; i < MVU_NUM_REGS; i++) begin
            check($sformatf("mvu_cfg_o[%0d]", i), m_cfg[i], mvu_cfg_o[i]);
        end
        @(posedge clk);
        case (op)
            CSR_SET:   nv = old | wdata;
            CSR_CLEAR: nv = old & ~wdata;
            default:   nv = wdata;
        endcase
        wr = acc && known && !ro;
        // a pulse never stretches over a back to back command write
        m_start   = wr && (addr == ADDR_MVUCMD) && !m_start;
        m_mip_mvu = m_mip_mvu | irq;
        if (wr) begin
            if (addr >= MVU_CSR_BASE && addr < MVU_CSR_BASE + 12'd16) m_cfg[addr[3:0]] = nv;
            case (addr)
                ADDR_MSTATUS: begin
                    m_mie  = nv[MSTATUS_MIE_BIT];
                    m_mpie = nv[MSTATUS_MPIE_BIT];
                end
                ADDR_MIE:   m_mie_mvu = nv[IRQ_MVU_BIT];
                ADDR_MIP:   m_mip_mvu = nv[IRQ_MVU_BIT] | irq;
                ADDR_MTVEC: m_mtvec = nv;
                ADDR_MEPC:  m_mepc = {nv[31:1], 1'b0};
                default:    ;
            endcase
        end
        if (take) begin
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mepc   = pc_i;
            m_mcause = MVU_IRQ_CAUSE;
        end else if (ret) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
        end
        if (cycle_en_i) m_cycle = m_cycle + 64'd1;
    endtask

    task automatic read_csr(input csr_addr_t addr);
        step(1'b1, CSR_SET, addr, '0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, CSR_NONE, '0, '0, 1'b0);
    endtask

    function automatic csr_addr_t pick_rw_addr();
        csr_addr_t a;
        case (rand_bits(3))
            3:       a = ADDR_MTVEC;
            4:       a = ADDR_MEPC;
            5:       a = ADDR_MIE;
            6:       a = ADDR_MSTATUS;
            default: a = MVU_CSR_BASE + csr_addr_t'(rand_bits(4));
        endcase
        return a;
    endfunction

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        int        n;
        csr_addr_t a;
        lfsr = 32'h256d5ca9;
        {checks, errors, test_errors, tests} = '0;
        {m_mie, m_mpie, m_mie_mvu, m_mip_mvu, m_start} = '0;
        m_mepc   = '0;
        m_mcause = '0;
        m_cycle  = '0;
        for (int i = 0; i < MVU_NUM_REGS; i++) m_cfg[i] = '0;
        count_en     = 1'b0;
        busy         = 1'b0;
        rst_n        = 1'b0;
        csr_valid_i  = 1'b0;
        csr_op_i     = CSR_NONE;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        pc_i         = '0;
        cycle_en_i   = 1'b0;
        mvu_irq_i    = 1'b0;
        mvu_status_i = 1'b0;
        boot_addr_i  = rand_bits(30) << 2;
        repeat (10) @(negedge clk);
        rst_n   = 1'b1;
        m_mtvec = boot_addr_i;

        foreach (RO_ADDRS[i]) read_csr(RO_ADDRS[i]);
        read_csr(ADDR_MTVEC);
        read_csr(ADDR_MISA);
        n = 20 + int'(rand_bits(4));
        count_en = 1'b1;
        idle(n);
        count_en = 1'b0;
        read_csr(ADDR_MCYCLE);
        check("mcycle count", 32'(n), csr_rdata_o);
        report_test("reset values");

        repeat (RW_COUNT) begin
            a = pick_rw_addr();
            step(1'b1, CSR_RW, a, rand_bits(32), 1'b0);
            read_csr(a);
        end
        report_test("read-write");

        repeat (SC_COUNT) begin
            a = pick_rw_addr();
            step(1'b1, rand_bits(1) ? CSR_SET : CSR_CLEAR, a, rand_bits(32), 1'b0);
        end
        report_test("set and clear");

        foreach (RO_ADDRS[i]) step(1'b1, CSR_RW, RO_ADDRS[i], rand_bits(32), 1'b0);
        // read only registers must still hold their old values
        foreach (RO_ADDRS[i]) read_csr(RO_ADDRS[i]);
        foreach (BAD_ADDRS[i]) step(1'b1, CSR_CLEAR, BAD_ADDRS[i], rand_bits(32), 1'b0);
        repeat (24) step(1'b1, CSR_RW, csr_addr_t'(rand_bits(12)), rand_bits(32), 1'b0);
        step(1'b1, CSR_RW, ADDR_MISA, rand_bits(32), 1'b0);
        read_csr(ADDR_MISA);
        report_test("illegal access");

        step(1'b1, CSR_RW, ADDR_MVUCMD, rand_bits(32), 1'b0);
        idle(2);
        step(1'b1, CSR_RW, MVU_CSR_BASE + 12'd3, rand_bits(32), 1'b0);
        idle(2);
        busy = 1'b1;
        read_csr(ADDR_MVUSTATUS);
        busy = 1'b0;
        read_csr(ADDR_MVUSTATUS);
        report_test("start pulse");

        step(1'b1, CSR_RW, ADDR_MIE, 32'(1) << IRQ_MVU_BIT, 1'b0);
        step(1'b1, CSR_RW, ADDR_MSTATUS, 32'(1) << MSTATUS_MIE_BIT, 1'b0);
        step(1'b0, CSR_NONE, '0, '0, 1'b1);
        idle(2);
        read_csr(ADDR_MEPC);
        read_csr(ADDR_MCAUSE);
        check("mcause value", MVU_IRQ_CAUSE, csr_rdata_o);
        read_csr(ADDR_MSTATUS);
        step(1'b1, CSR_CLEAR, ADDR_MIP, 32'(1) << IRQ_MVU_BIT, 1'b0);
        step(1'b1, CSR_MRET, '0, '0, 1'b0);
        read_csr(ADDR_MSTATUS);
        report_test("interrupt and mret");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
